//--- source/attn_buf_pkg.sv
package attn_buf_pkg;

    localparam int MAT_ROWS  = 16;  // rows per matrix
    localparam int MAT_COLS  = 8;   // bytes per row
    localparam int BEAT_ROWS = 4;   // rows per ram word
    localparam int BEATS     = 4;   // ram words per matrix
    localparam int READ_LAT  = 2;   // ram read latency

    typedef logic [7:0] elem_t;

    typedef logic [MAT_COLS*$bits(elem_t)-1:0] row_t;

    // upper 2 bits pick the operand kind, lower 4 bits the line
    typedef logic [5:0] slot_t;

    typedef logic [$clog2(BEATS)-1:0] beat_t;

    typedef logic [$bits(slot_t)+$bits(beat_t)-1:0] ram_addr_t;  // {slot, beat}

    typedef logic [BEAT_ROWS*$bits(row_t)-1:0] ram_word_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_DELAY,
        S_RD_GATHER,
        S_RD_FINISH,
        S_WR_BEATS
    } mgr_state_t;

endpackage

//--- source/beat_ram.sv
`timescale 1ns/100ps

module beat_ram (
    input  logic                   I_CLK,
    input  logic                   en,
    input  logic                   we,
    input  attn_buf_pkg::ram_addr_t addr,
    input  attn_buf_pkg::ram_word_t din,
    output attn_buf_pkg::ram_word_t dout
);

    import attn_buf_pkg::*;

    ram_word_t mem [2**$bits(ram_addr_t)];
    ram_word_t rd_pipe [READ_LAT];  // output register chain

    always_ff @(posedge I_CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end
            rd_pipe[0] <= mem[addr];  // read first
        end
    end

    always_ff @(posedge I_CLK) begin
        for (int i = 1; i < READ_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign dout = rd_pipe[READ_LAT-1];

endmodule

//--- source/bram_manager.sv
`timescale 1ns/100ps

module bram_manager (
    input  logic                    I_CLK,
    input  logic                    I_RST_N,
    input  logic                    rd_pulse,
    input  logic                    wr_pulse,
    input  attn_buf_pkg::slot_t     slot,
    input  attn_buf_pkg::row_t      wr_mat [attn_buf_pkg::MAT_ROWS],
    output logic                    ram_en,
    output logic                    ram_we,
    output attn_buf_pkg::ram_addr_t ram_addr,
    output attn_buf_pkg::ram_word_t ram_din,
    input  attn_buf_pkg::ram_word_t ram_dout,
    output logic                    rd_vld,
    output attn_buf_pkg::row_t      rd_mat [attn_buf_pkg::MAT_ROWS],
    output logic                    wr_done
);

    import attn_buf_pkg::*;

    mgr_state_t state;
    slot_t      slot_q;   // held for the whole operation
    beat_t      beat;     // beat on the ram address
    beat_t      gat;      // beat landing in rd_mat
    logic [$clog2(READ_LAT+1)-1:0] dly;

    assign ram_addr = {slot_q, beat};

    // four rows of the source matrix per ram word
    always_comb begin
        for (int i = 0; i < BEAT_ROWS; i++) begin
            ram_din[i*$bits(row_t) +: $bits(row_t)] = wr_mat[beat*BEAT_ROWS + i];
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state   <= S_IDLE;
            beat    <= '0;
            gat     <= '0;
            dly     <= '0;
            ram_en  <= 1'b0;
            ram_we  <= 1'b0;
            rd_vld  <= 1'b0;
            wr_done <= 1'b0;
        end else if (wr_pulse) begin  // write wins, restarts anything
            state   <= S_WR_BEATS;
            beat    <= '0;
            ram_en  <= 1'b1;
            ram_we  <= 1'b1;
            wr_done <= 1'b0;
        end else if (rd_pulse) begin
            state  <= S_RD_DELAY;
            beat   <= '0;
            dly    <= '0;
            ram_en <= 1'b1;
            ram_we <= 1'b0;
            rd_vld <= 1'b0;
        end else begin
            case (state)
                S_WR_BEATS: begin
                    if (ram_we) begin
                        if (beat == BEATS-1) begin
                            ram_en <= 1'b0;
                            ram_we <= 1'b0;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end else begin  // last beat went in on the previous edge
                        wr_done <= 1'b1;
                        state   <= S_IDLE;
                    end
                end
                S_RD_DELAY: begin
                    if (beat == BEATS-1) begin
                        ram_en <= 1'b0;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                    if (dly == READ_LAT-1) begin
                        gat   <= '0;
                        state <= S_RD_GATHER;  // beat 0 on dout now
                    end else begin
                        dly <= dly + 1'b1;
                    end
                end
                S_RD_GATHER: begin
                    if (beat == BEATS-1) begin
                        ram_en <= 1'b0;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                    if (gat == BEATS-1) begin
                        state <= S_RD_FINISH;
                    end else begin
                        gat <= gat + 1'b1;
                    end
                end
                S_RD_FINISH: begin
                    rd_vld <= 1'b1;
                    state  <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge I_CLK) begin
        if (wr_pulse || rd_pulse) begin
            slot_q <= slot;
        end
    end

    // returning words fill rd_mat a quarter at a time
    always_ff @(posedge I_CLK) begin
        if (!wr_pulse && !rd_pulse && state == S_RD_GATHER) begin
            for (int i = 0; i < BEAT_ROWS; i++) begin
                rd_mat[gat*BEAT_ROWS + i] <= ram_dout[i*$bits(row_t) +: $bits(row_t)];
            end
        end
    end

endmodule

//--- source/row_collector.sv
`timescale 1ns/100ps

module row_collector (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                row_vld,
    input  attn_buf_pkg::row_t  row,
    input  attn_buf_pkg::slot_t wr_slot,
    output logic                wr_pulse,
    output attn_buf_pkg::slot_t slot,
    output attn_buf_pkg::row_t  mat [attn_buf_pkg::MAT_ROWS]
);

    import attn_buf_pkg::*;

    logic [$clog2(MAT_ROWS)-1:0] cnt;
    logic                        last_row;
    row_t                        fill [MAT_ROWS-1];  // rows before the last
    slot_t                       slot_fill;

    assign last_row = row_vld && (cnt == MAT_ROWS-1);

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            cnt      <= '0;
            wr_pulse <= 1'b0;
        end else begin
            wr_pulse <= last_row;
            if (row_vld) begin
                cnt <= cnt + 1'b1;  // wraps to row 0
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (row_vld && !last_row) begin
            fill[cnt] <= row;
        end
        if (row_vld && cnt == '0) begin
            slot_fill <= wr_slot;  // slot rides with row 0
        end
        // hand over a stable copy so the next matrix can start filling
        if (last_row) begin
            for (int i = 0; i < MAT_ROWS-1; i++) begin
                mat[i] <= fill[i];
            end
            mat[MAT_ROWS-1] <= row;
            slot            <= slot_fill;
        end
    end

endmodule

//--- source/row_serializer.sv
`timescale 1ns/100ps

module row_serializer (
    input  logic               I_CLK,
    input  logic               I_RST_N,
    input  logic               rd_vld,
    input  attn_buf_pkg::row_t rd_mat [attn_buf_pkg::MAT_ROWS],
    output logic               out_row_vld,
    output attn_buf_pkg::row_t out_row,
    output logic               out_row_last
);

    import attn_buf_pkg::*;

    logic                        rd_vld_q;
    logic                        start;
    logic [$clog2(MAT_ROWS)-1:0] cnt;  // next row to send

    assign start = rd_vld && !rd_vld_q;

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            rd_vld_q     <= 1'b0;
            cnt          <= '0;
            out_row_vld  <= 1'b0;
            out_row_last <= 1'b0;
        end else begin
            rd_vld_q <= rd_vld;
            if (start) begin
                out_row_vld  <= 1'b1;
                out_row_last <= 1'b0;
                cnt          <= 1'b1;
            end else if (out_row_vld && !out_row_last && rd_vld) begin
                cnt          <= cnt + 1'b1;
                out_row_last <= (cnt == MAT_ROWS-1);
            end else begin  // done, or matrix withdrawn by a new read
                out_row_vld  <= 1'b0;
                out_row_last <= 1'b0;
                cnt          <= '0;
            end
        end
    end

    // cnt is back at row 0 whenever a new stream starts
    always_ff @(posedge I_CLK) begin
        out_row <= rd_mat[cnt];
    end

endmodule

//--- source/attn_buf_top.sv
`timescale 1ns/100ps

module attn_buf_top (
    input  logic                I_CLK,
    input  logic                I_RST_N,
    input  logic                row_vld,
    input  attn_buf_pkg::row_t  row,
    input  attn_buf_pkg::slot_t wr_slot,
    input  logic                rd_pulse,
    input  attn_buf_pkg::slot_t rd_slot,
    output logic                wr_done,
    output logic                out_row_vld,
    output attn_buf_pkg::row_t  out_row,
    output logic                out_row_last
);

    import attn_buf_pkg::*;

    logic      col_wr_pulse;
    slot_t     col_slot;
    row_t      col_mat [MAT_ROWS];
    slot_t     mgr_slot;
    logic      ram_en;
    logic      ram_we;
    ram_addr_t ram_addr;
    ram_word_t ram_din;
    ram_word_t ram_dout;
    logic      rd_vld;
    row_t      rd_mat [MAT_ROWS];

    assign mgr_slot = col_wr_pulse ? col_slot : rd_slot;  // write has priority

    row_collector u_row_collector (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .row_vld  (row_vld),
        .row      (row),
        .wr_slot  (wr_slot),
        .wr_pulse (col_wr_pulse),
        .slot     (col_slot),
        .mat      (col_mat)
    );

    bram_manager u_bram_manager (
        .I_CLK    (I_CLK),
        .I_RST_N  (I_RST_N),
        .rd_pulse (rd_pulse),
        .wr_pulse (col_wr_pulse),
        .slot     (mgr_slot),
        .wr_mat   (col_mat),
        .ram_en   (ram_en),
        .ram_we   (ram_we),
        .ram_addr (ram_addr),
        .ram_din  (ram_din),
        .ram_dout (ram_dout),
        .rd_vld   (rd_vld),
        .rd_mat   (rd_mat),
        .wr_done  (wr_done)
    );

    beat_ram u_beat_ram (
        .I_CLK (I_CLK),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .din   (ram_din),
        .dout  (ram_dout)
    );

    row_serializer u_row_serializer (
        .I_CLK        (I_CLK),
        .I_RST_N      (I_RST_N),
        .rd_vld       (rd_vld),
        .rd_mat       (rd_mat),
        .out_row_vld  (out_row_vld),
        .out_row      (out_row),
        .out_row_last (out_row_last)
    );

endmodule

//--- dv/attn_buf_assertions.sv
`timescale 1ns/100ps

module attn_buf_assertions (
    input logic I_CLK,
    input logic I_RST_N,
    input logic rd_pulse,
    input logic wr_pulse,
    input logic ram_en,
    input logic ram_we,
    input logic rd_vld,
    input logic wr_done
);

    int fail_cnt = 0;  // assertion failures so far

    we_needs_en: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        ram_we |-> ram_en)
        else begin
            fail_cnt++;
            $error("ram_we high while ram_en low");
        end

    wr_pulse_clears_done: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        wr_pulse |=> !wr_done)
        else begin
            fail_cnt++;
            $error("wr_done not cleared by write pulse");
        end

    wr_done_latency: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        wr_pulse ##1 (!wr_pulse && !rd_pulse)[*5] |=> $rose(wr_done))
        else begin
            fail_cnt++;
            $error("wr_done not 5 cycles after write pulse");
        end

    rd_vld_latency: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (rd_pulse && !wr_pulse) ##1 (!wr_pulse && !rd_pulse)[*7] |=> $rose(rd_vld))
        else begin
            fail_cnt++;
            $error("rd_vld not 7 cycles after read pulse");
        end

endmodule

bind bram_manager attn_buf_assertions u_mgr_assertions (
    .I_CLK    (I_CLK),
    .I_RST_N  (I_RST_N),
    .rd_pulse (rd_pulse),
    .wr_pulse (wr_pulse),
    .ram_en   (ram_en),
    .ram_we   (ram_we),
    .rd_vld   (rd_vld),
    .wr_done  (wr_done)
);

//--- dv/attn_buf_tb.sv
`timescale 1ns/100ps

module attn_buf_tb;

    import attn_buf_pkg::*;

    localparam int N_OPS     = 15;
    localparam int DRIVE_DLY = 2;   // ns after the rising edge
    localparam int WAIT_MAX  = 30;  // cycles before a wait gives up

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_ABORT} op_t;

    typedef struct packed {
        op_t   op;
        slot_t slot;
        slot_t next_slot;  // second read of an abort
    } op_entry_t;

    logic  I_CLK;
    logic  I_RST_N;
    logic  row_vld;
    row_t  row;
    slot_t wr_slot;
    logic  rd_pulse;
    slot_t rd_slot;
    logic  wr_done;
    logic  out_row_vld;
    row_t  out_row;
    logic  out_row_last;

    op_entry_t   ops [N_OPS];
    row_t        model [2**$bits(slot_t)][MAT_ROWS];  // expected rows per slot
    logic [15:0] lfsr;

    attn_buf_top uut (
        .I_CLK        (I_CLK),
        .I_RST_N      (I_RST_N),
        .row_vld      (row_vld),
        .row          (row),
        .wr_slot      (wr_slot),
        .rd_pulse     (rd_pulse),
        .rd_slot      (rd_slot),
        .wr_done      (wr_done),
        .out_row_vld  (out_row_vld),
        .out_row      (out_row),
        .out_row_last (out_row_last)
    );

    initial begin
        I_CLK = 1'b0;
        forever #20 I_CLK = ~I_CLK;
    end

    task automatic halt_failed();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        halt_failed();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        halt_failed();
    endtask

    initial begin
        repeat (N_OPS*40) @(posedge I_CLK);
        report_problem("watchdog expired before the operation table finished");
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_row(output row_t r);
        r = '0;
        for (int b = 0; b < $bits(row_t); b++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[$bits(row_t)-2:0], lfsr[0]};
        end
    endtask

    task automatic step_cycle();
        @(posedge I_CLK);
        #DRIVE_DLY;
    endtask

    task automatic write_matrix(input slot_t slot);
        int   cycles;
        row_t r;
        for (int i = 0; i < MAT_ROWS; i++) begin
            step_cycle();
            random_row(r);
            model[slot][i] = r;
            row_vld        = 1'b1;
            row            = r;
            wr_slot        = slot;
        end
        step_cycle();  // last row taken on this edge
        row_vld = 1'b0;
        cycles  = 0;
        do begin
            step_cycle();
            cycles++;
        end while (!wr_done && cycles < WAIT_MAX);
        assert (wr_done)
            else report_problem($sformatf("wr_done never rose for slot %0h", slot));
        assert (cycles == 6)
            else report_mismatch("wr_done latency from last row", 6, cycles);
    endtask

    task automatic issue_read(input slot_t slot);
        step_cycle();
        rd_pulse = 1'b1;
        rd_slot  = slot;
        step_cycle();
        rd_pulse = 1'b0;
    endtask

    task automatic check_stream(input slot_t slot);
        int cycles;
        cycles = 0;
        do begin
            step_cycle();
            cycles++;
        end while (!out_row_vld && cycles < WAIT_MAX);
        assert (out_row_vld)
            else report_problem($sformatf("no rows came out for read of slot %0h", slot));
        assert (cycles == 8)
            else report_mismatch("out_row_vld latency from rd_pulse", 8, cycles);
        for (int k = 0; k < MAT_ROWS; k++) begin
            if (k > 0) begin
                step_cycle();
            end
            assert (out_row_vld)
                else report_mismatch($sformatf("out_row_vld row %0d", k), 1, out_row_vld);
            assert (out_row == model[slot][k])
                else report_mismatch($sformatf("out_row slot %0h row %0d", slot, k),
                                     model[slot][k], out_row);
            assert (out_row_last == (k == MAT_ROWS-1))
                else report_mismatch($sformatf("out_row_last row %0d", k),
                                     (k == MAT_ROWS-1), out_row_last);
        end
        step_cycle();
        assert (!out_row_vld)
            else report_mismatch("out_row_vld after last row", 0, out_row_vld);
    endtask

    initial begin
        I_RST_N  = 1'b0;
        row_vld  = 1'b0;
        row      = '0;
        wr_slot  = '0;
        rd_pulse = 1'b0;
        rd_slot  = '0;
        lfsr     = 16'd82;
        ops = '{
            '{OP_WRITE, 6'h03, 6'h00},
            '{OP_WRITE, 6'h13, 6'h00},  // same line, other kinds
            '{OP_WRITE, 6'h23, 6'h00},
            '{OP_WRITE, 6'h33, 6'h00},
            '{OP_WRITE, 6'h0A, 6'h00},
            '{OP_READ,  6'h23, 6'h00},
            '{OP_READ,  6'h03, 6'h00},
            '{OP_READ,  6'h33, 6'h00},
            '{OP_READ,  6'h0A, 6'h00},
            '{OP_READ,  6'h13, 6'h00},
            '{OP_ABORT, 6'h03, 6'h33},
            '{OP_WRITE, 6'h13, 6'h00},  // overwrite
            '{OP_READ,  6'h13, 6'h00},
            '{OP_ABORT, 6'h13, 6'h0A},
            '{OP_READ,  6'h03, 6'h00}
        };

        repeat (3) @(posedge I_CLK);
        #DRIVE_DLY;
        I_RST_N = 1'b1;
        assert (!wr_done) else report_mismatch("wr_done after reset", 0, wr_done);
        assert (!out_row_vld) else report_mismatch("out_row_vld after reset", 0, out_row_vld);

        for (int i = 0; i < N_OPS; i++) begin
            case (ops[i].op)
                OP_WRITE: begin
                    write_matrix(ops[i].slot);
                end
                OP_READ: begin
                    issue_read(ops[i].slot);
                    check_stream(ops[i].slot);
                end
                default: begin  // second read lands mid-gather
                    issue_read(ops[i].slot);
                    repeat (2) step_cycle();
                    assert (!out_row_vld)
                        else report_mismatch("out_row_vld before abort", 0, out_row_vld);
                    issue_read(ops[i].next_slot);
                    check_stream(ops[i].next_slot);
                end
            endcase
            step_cycle();
        end

        repeat (2) step_cycle();
        if (uut.u_bram_manager.u_mgr_assertions.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            report_problem("bound manager assertions reported failures");
        end
    end

endmodule

//--- all.f
source/attn_buf_pkg.sv
source/beat_ram.sv
source/bram_manager.sv
source/row_collector.sv
source/row_serializer.sv
source/attn_buf_top.sv
dv/attn_buf_assertions.sv
dv/attn_buf_tb.sv
